// File: src/i2c_pkg.sv
package i2c_pkg;

	typedef logic [6:0] dev_addr_t;	// 7-bit slave address
	typedef logic [7:0] byte_t;	// reg address, write or read data

	// commands from the sequencer to the byte shifter
	typedef enum logic [2:0] {
		BYTE_START,
		BYTE_RESTART,
		BYTE_WRITE,
		BYTE_READ,
		BYTE_STOP
	} byte_op_e;

	// single bus operations run by the bit engine
	typedef enum logic [2:0] {
		BIT_START,
		BIT_RESTART,
		BIT_SEND,
		BIT_SAMPLE,
		BIT_STOP
	} bit_op_e;

	localparam int unsigned SCL_HALF_CYCLES_DEFAULT = 32'd1;	// clk_in cycles per scl phase

endpackage

// File: src/i2c_byte_if.sv
`timescale 1ns/1ps

interface i2c_byte_if;
	import i2c_pkg::*;

	logic byte_go;	// one-cycle command strobe
	byte_op_e byte_op;
	byte_t byte_tx;
	logic byte_done;	// one-cycle completion pulse
	logic byte_ack;	// slave acked, valid with byte_done
	byte_t byte_rx;

	modport seq (
		output byte_go, byte_op, byte_tx,
		input byte_done, byte_ack, byte_rx
	);

	modport shf (
		input byte_go, byte_op, byte_tx,
		output byte_done, byte_ack, byte_rx
	);

endinterface

// File: src/i2c_bit_if.sv
`timescale 1ns/1ps

interface i2c_bit_if;
	import i2c_pkg::*;

	logic bit_go;
	bit_op_e bit_op;
	logic bit_tx;
	logic bit_done;
	logic bit_rx;	// sda at the end of the high phase

	modport shf (
		output bit_go, bit_op, bit_tx,
		input bit_done, bit_rx
	);

	modport eng (
		input bit_go, bit_op, bit_tx,
		output bit_done, bit_rx
	);

endinterface

// File: src/i2c_txn_sequencer.sv
`timescale 1ns/1ps

module i2c_txn_sequencer (
	input logic clk_in,
	input logic rst_n,
	input logic start,
	input logic rw,
	input i2c_pkg::dev_addr_t dev_addr,
	input i2c_pkg::byte_t reg_addr,
	input i2c_pkg::byte_t wr_data,
	output logic busy,
	output logic done,
	output logic nack,
	output i2c_pkg::byte_t rd_data,
	i2c_byte_if.seq byte_if
);
	import i2c_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_START,
		S_DEV_W,
		S_REG,
		S_DATA,
		S_RESTART,
		S_DEV_R,
		S_READ,
		S_STOP
	} state_e;

	state_e state;
	state_e state_nx;
	logic rw_q;
	dev_addr_t dev_q;
	byte_t reg_q;
	byte_t wr_q;
	logic cmd_open;	// command issued, byte_done not yet seen
	logic step;
	logic refused;
	byte_op_e byte_op_c;
	byte_t byte_tx_c;

	assign step = cmd_open && byte_if.byte_done;
	assign refused = step && !byte_if.byte_ack && (byte_op_c == BYTE_WRITE);

	always_comb begin
		state_nx = state;
		if (state == S_IDLE) begin
			if (start)
				state_nx = S_START;
		end else if (refused) begin
			state_nx = S_STOP;	// slave nack, close the bus
		end else if (step) begin
			case (state)
				S_START: state_nx = S_DEV_W;
				S_DEV_W: state_nx = S_REG;
				S_REG: begin
					if (rw_q)
						state_nx = S_RESTART;
					else
						state_nx = S_DATA;
				end
				S_DATA: state_nx = S_STOP;
				S_RESTART: state_nx = S_DEV_R;
				S_DEV_R: state_nx = S_READ;
				S_READ: state_nx = S_STOP;
				default: state_nx = S_IDLE;
			endcase
		end
	end

	always_comb begin
		byte_op_c = BYTE_WRITE;
		byte_tx_c = '0;
		case (state)
			S_START: byte_op_c = BYTE_START;
			S_DEV_W: byte_tx_c = {dev_q, 1'b0};
			S_REG: byte_tx_c = reg_q;
			S_DATA: byte_tx_c = wr_q;
			S_RESTART: byte_op_c = BYTE_RESTART;
			S_DEV_R: byte_tx_c = {dev_q, 1'b1};	// read bit
			S_READ: byte_op_c = BYTE_READ;
			S_STOP: byte_op_c = BYTE_STOP;
			default: ;
		endcase
	end

	assign byte_if.byte_op = byte_op_c;
	assign byte_if.byte_tx = byte_tx_c;

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			busy <= 1'b0;
			done <= 1'b0;
			nack <= 1'b0;
			rd_data <= '0;
			cmd_open <= 1'b0;
			byte_if.byte_go <= 1'b0;
		end else begin
			state <= state_nx;
			done <= 1'b0;
			byte_if.byte_go <= (state_nx != state) && (state_nx != S_IDLE);
			if (state == S_IDLE && start) begin
				busy <= 1'b1;
				nack <= 1'b0;
			end
			if (refused)
				nack <= 1'b1;
			if (step && state == S_READ)
				rd_data <= byte_if.byte_rx;
			if (step && state == S_STOP) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (byte_if.byte_go)
				cmd_open <= 1'b1;
			else if (step)
				cmd_open <= 1'b0;
		end
	end

	always_ff @(posedge clk_in) begin
		if (state == S_IDLE && start) begin
			rw_q <= rw;
			dev_q <= dev_addr;
			reg_q <= reg_addr;
			wr_q <= wr_data;
		end
	end

	// shifter takes one command at a time
	assert property (@(posedge clk_in) disable iff (!rst_n) byte_if.byte_go |-> !cmd_open);

endmodule

// File: src/i2c_byte_shifter.sv
`timescale 1ns/1ps

module i2c_byte_shifter (
	input logic clk_in,
	input logic rst_n,
	i2c_byte_if.shf byte_if,
	i2c_bit_if.shf bit_if
);
	import i2c_pkg::*;

	byte_op_e op_q;
	byte_t sr;
	logic [3:0] bit_cnt;	// bits issued for this command
	logic active;
	logic is_cond;
	logic last_bit;
	bit_op_e bit_op_c;
	logic bit_tx_c;

	assign is_cond = (op_q != BYTE_WRITE) && (op_q != BYTE_READ);
	assign last_bit = is_cond || (bit_cnt == 4'd9);

	always_comb begin
		bit_op_c = BIT_STOP;
		bit_tx_c = 1'b1;	// master nack after a read
		case (op_q)
			BYTE_START: bit_op_c = BIT_START;
			BYTE_RESTART: bit_op_c = BIT_RESTART;
			BYTE_WRITE: begin
				bit_tx_c = sr[7];
				if (bit_cnt == 4'd9)
					bit_op_c = BIT_SAMPLE;
				else
					bit_op_c = BIT_SEND;
			end
			BYTE_READ: begin
				if (bit_cnt == 4'd9)
					bit_op_c = BIT_SEND;
				else
					bit_op_c = BIT_SAMPLE;
			end
			default: ;
		endcase
	end

	assign bit_if.bit_op = bit_op_c;
	assign bit_if.bit_tx = bit_tx_c;

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			op_q <= BYTE_STOP;
			bit_cnt <= '0;
			bit_if.bit_go <= 1'b0;
		end else begin
			bit_if.bit_go <= 1'b0;
			if (!active) begin
				if (byte_if.byte_go) begin
					active <= 1'b1;
					op_q <= byte_if.byte_op;
					bit_cnt <= 4'd1;
					bit_if.bit_go <= 1'b1;
				end
			end else if (bit_if.bit_done) begin
				if (last_bit) begin
					active <= 1'b0;
					bit_cnt <= '0;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					bit_if.bit_go <= 1'b1;
				end
			end
		end
	end

	// msb first both ways, read bits enter at the bottom
	always_ff @(posedge clk_in) begin
		if (!active && byte_if.byte_go)
			sr <= byte_if.byte_tx;
		else if (active && bit_if.bit_done && bit_cnt <= 4'd8)
			sr <= {sr[6:0], bit_if.bit_rx};
	end

	assign byte_if.byte_done = active && bit_if.bit_done && last_bit;
	assign byte_if.byte_ack = (op_q == BYTE_WRITE) ? ~bit_if.bit_rx : 1'b1;
	assign byte_if.byte_rx = sr;

	assert property (@(posedge clk_in) disable iff (!rst_n) bit_cnt <= 4'd9);

endmodule

// File: src/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine #(
	parameter int unsigned scl_half_cycles = i2c_pkg::SCL_HALF_CYCLES_DEFAULT
) (
	input logic clk_in,
	input logic rst_n,
	i2c_bit_if.eng bit_if,
	input logic sda_in,
	output logic scl,
	output logic sda_out,
	output logic sda_oe
);
	import i2c_pkg::*;

	localparam int CNT_W = $clog2(scl_half_cycles + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(scl_half_cycles - 1);

	// cond and tail carry the sda level after a start, restart or stop edge
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_LOW,
		PH_HIGH,
		PH_COND,
		PH_TAIL
	} phase_e;

	phase_e phase;
	phase_e phase_follow;
	logic [CNT_W-1:0] cnt;
	bit_op_e op_q;	// last op, bit_stop means bus free
	logic tx_q;
	logic is_data;
	logic phase_end;
	logic use_post;
	logic pre_oe;
	logic pre_out;
	logic post_oe;
	logic post_out;

	assign is_data = (op_q == BIT_SEND) || (op_q == BIT_SAMPLE);

	always_comb begin
		pre_oe = 1'b1;
		pre_out = 1'b1;
		post_oe = 1'b1;
		post_out = 1'b0;
		case (op_q)
			BIT_SEND: pre_out = tx_q;
			BIT_SAMPLE: pre_oe = 1'b0;	// slave owns sda
			BIT_STOP: begin
				pre_out = 1'b0;
				post_oe = 1'b0;	// released, pull-up makes the stop
				post_out = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (phase)
			PH_LOW: phase_follow = PH_HIGH;
			PH_HIGH: phase_follow = is_data ? PH_IDLE : PH_COND;
			PH_COND: phase_follow = (op_q == BIT_STOP) ? PH_IDLE : PH_TAIL;
			default: phase_follow = PH_IDLE;
		endcase
	end

	assign phase_end = (phase != PH_IDLE) && (cnt == CNT_LAST);
	assign bit_if.bit_done = phase_end && (phase_follow == PH_IDLE);
	assign bit_if.bit_rx = sda_in;	// taken at the closing edge of the high phase

	// lines follow the phase, idle holds the level of the last phase
	assign use_post = (phase == PH_COND) || (phase == PH_TAIL)
		|| (phase == PH_IDLE && !is_data);
	assign scl = (phase == PH_HIGH) || (phase == PH_COND)
		|| (phase == PH_IDLE && op_q == BIT_STOP);
	assign sda_oe = use_post ? post_oe : pre_oe;
	assign sda_out = use_post ? post_out : pre_out;

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			cnt <= '0;
			op_q <= BIT_STOP;
		end else if (phase == PH_IDLE) begin
			if (bit_if.bit_go) begin
				op_q <= bit_if.bit_op;
				if (bit_if.bit_op == BIT_START)
					phase <= PH_HIGH;	// scl already high on a free bus
				else
					phase <= PH_LOW;
			end
		end else if (phase_end) begin
			cnt <= '0;
			phase <= phase_follow;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (phase == PH_IDLE && bit_if.bit_go)
			tx_q <= bit_if.bit_tx;
	end

	// start only on a free bus
	assert property (@(posedge clk_in) disable iff (!rst_n)
		(phase == PH_IDLE && bit_if.bit_go && bit_if.bit_op == BIT_START)
		|-> (scl && !sda_oe));

endmodule

// File: src/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top #(
	parameter int unsigned scl_half_cycles = i2c_pkg::SCL_HALF_CYCLES_DEFAULT
) (
	input logic clk_in,
	input logic rst_n,
	input logic start,
	input logic rw,	// 1 = read
	input i2c_pkg::dev_addr_t dev_addr,
	input i2c_pkg::byte_t reg_addr,
	input i2c_pkg::byte_t wr_data,
	input logic sda_in,
	output logic busy,
	output logic done,
	output logic nack,
	output i2c_pkg::byte_t rd_data,
	output logic scl,
	output logic sda_out,
	output logic sda_oe
);

	i2c_byte_if byte_bus ();
	i2c_bit_if bit_bus ();

	i2c_txn_sequencer seq_i (
		.clk_in (clk_in),
		.rst_n (rst_n),
		.start (start),
		.rw (rw),
		.dev_addr (dev_addr),
		.reg_addr (reg_addr),
		.wr_data (wr_data),
		.busy (busy),
		.done (done),
		.nack (nack),
		.rd_data (rd_data),
		.byte_if (byte_bus.seq)
	);

	i2c_byte_shifter shf_i (
		.clk_in (clk_in),
		.rst_n (rst_n),
		.byte_if (byte_bus.shf),
		.bit_if (bit_bus.shf)
	);

	i2c_bit_engine #(
		.scl_half_cycles (scl_half_cycles)
	) eng_i (
		.clk_in (clk_in),
		.rst_n (rst_n),
		.bit_if (bit_bus.eng),
		.sda_in (sda_in),
		.scl (scl),
		.sda_out (sda_out),
		.sda_oe (sda_oe)
	);

endmodule

// File: sim/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] dev_addr = 7'h00
) (
	input logic clk_in,
	input logic scl,
	input logic sda,	// resolved bus line
	output logic sda_pull
);

	logic [7:0] regs [0:255];
	int start_cnt = 0;
	int restart_cnt = 0;
	int stop_cnt = 0;
	int proto_errs = 0;

	logic scl_q = 1'b1;
	logic sda_q = 1'b1;
	logic [3:0] cnt = '0;	// rising scl edges in this byte
	logic [1:0] idx = '0;	// byte index since the last start
	logic [7:0] sh = '0;
	logic [7:0] ptr = '0;
	logic [7:0] tx = '0;
	logic in_txn = 1'b0;
	logic hit = 1'b0;
	logic rd_mode = 1'b0;

	initial sda_pull = 1'b0;

	// bus sampled mid-cycle, so edges that share a time step never look like conditions
	always @(negedge clk_in) begin
		if (scl_q && scl && sda_q != sda) begin
			// inside a txn the condition's own scl rise is already counted
			assert (cnt == (in_txn ? 4'd1 : 4'd0)) else begin
				$display("framing error at %0t: sda moved while scl high inside a byte", $time);
				proto_errs++;
			end
			if (!sda) begin
				if (in_txn)
					restart_cnt++;
				else
					start_cnt++;
				in_txn = 1'b1;
				idx = '0;
				hit = 1'b0;
				rd_mode = 1'b0;
			end else begin
				stop_cnt++;
				in_txn = 1'b0;
				hit = 1'b0;
			end
			sda_pull = 1'b0;
			cnt = '0;
		end else if (!scl_q && scl && in_txn) begin
			cnt++;
			if (cnt <= 8)
				sh = {sh[6:0], sda};
		end else if (scl_q && !scl && in_txn) begin
			if (cnt == 8) begin
				sda_pull = 1'b0;
				if (idx == 0) begin
					hit = (sh[7:1] == dev_addr);
					rd_mode = hit && sh[0];
					sda_pull = hit;	// ack own address only
				end else if (hit && !rd_mode) begin
					if (idx == 1)
						ptr = sh;
					else
						regs[ptr] = sh;
					sda_pull = 1'b1;
				end
			end else if (cnt == 9) begin
				cnt = '0;
				idx++;
				sda_pull = 1'b0;
				if (rd_mode && idx == 1) begin
					tx = regs[ptr];
					sda_pull = !tx[7];
				end
			end else if (rd_mode && idx == 1 && cnt >= 1) begin
				sda_pull = !tx[7 - cnt];	// next read bit, msb first
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

// File: sim/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master;
	import i2c_pkg::*;

	localparam dev_addr_t TB_DEV_ADDR = 7'h48;
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk_in = 1'b0;
	logic rst_n;
	logic start;
	logic rw;
	dev_addr_t dev_addr;
	byte_t reg_addr;
	byte_t wr_data;
	logic busy;
	logic done;
	logic nack;
	byte_t rd_data;
	logic scl;
	logic sda_out;
	logic sda_oe;
	logic slave_pull;
	wire sda_line;

	int errors = 0;
	int timeouts = 0;
	int starts_0;
	int restarts_0;
	int stops_0;
	logic [31:0] lcg_state = 32'h9baf;
	byte_t exp_regs [0:255];
	logic written [0:255];

	assign sda_line = !((sda_oe && !sda_out) || slave_pull);	// open drain

	always #50 clk_in = ~clk_in;

	i2c_master_top i2c_master_top_i (
		.clk_in (clk_in),
		.rst_n (rst_n),
		.start (start),
		.rw (rw),
		.dev_addr (dev_addr),
		.reg_addr (reg_addr),
		.wr_data (wr_data),
		.sda_in (sda_line),
		.busy (busy),
		.done (done),
		.nack (nack),
		.rd_data (rd_data),
		.scl (scl),
		.sda_out (sda_out),
		.sda_oe (sda_oe)
	);

	i2c_slave_model #(
		.dev_addr (TB_DEV_ADDR)
	) slave_i (
		.clk_in (clk_in),
		.scl (scl),
		.sda (sda_line),
		.sda_pull (slave_pull)
	);

	function automatic byte_t lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		errors++;
	endtask

	// one transaction, busy checked every cycle until done
	task automatic run_txn(input logic rd, input dev_addr_t dev, input byte_t ra,
			input byte_t wd, input logic dup, output logic got_done);
		int i;
		got_done = 1'b0;
		starts_0 = slave_i.start_cnt;
		restarts_0 = slave_i.restart_cnt;
		stops_0 = slave_i.stop_cnt;
		@(posedge clk_in);
		start <= 1'b1;
		rw <= rd;
		dev_addr <= dev;
		reg_addr <= ra;
		wr_data <= wd;
		for (i = 0; i < TIMEOUT_CYCLES && !got_done; i++) begin
			@(posedge clk_in);
			start <= dup && (i == 5);	// second pulse while busy
			@(negedge clk_in);
			if (done) begin
				got_done = 1'b1;
				assert (!busy) else report_mismatch("busy still high with done");
			end else begin
				assert (busy) else report_mismatch("busy low before done");
			end
		end
		if (!got_done) begin
			$display("timeout at %0t: done never came", $time);
			timeouts++;
		end
	endtask

	task automatic check_framing(input int es, input int er, input int ep);
		int ds;
		int dr;
		int dp;
		ds = slave_i.start_cnt - starts_0;
		dr = slave_i.restart_cnt - restarts_0;
		dp = slave_i.stop_cnt - stops_0;
		assert (ds == es && dr == er && dp == ep) else
			report_mismatch($sformatf("start/restart/stop %0d/%0d/%0d, expected %0d/%0d/%0d",
				ds, dr, dp, es, er, ep));
	endtask

	initial begin
		int k;
		byte_t r;
		byte_t d;
		logic ok;
		rst_n = 1'b0;
		start = 1'b0;
		rw = 1'b0;
		dev_addr = '0;
		reg_addr = '0;
		wr_data = '0;
		for (k = 0; k < 256; k++) begin
			exp_regs[k] = lcg_byte();
			slave_i.regs[k] = exp_regs[k];
			written[k] = 1'b0;
		end
		repeat (2) @(posedge clk_in);
		rst_n <= 1'b1;
		@(negedge clk_in);
		assert (!busy && !done && !nack && scl && !sda_oe) else
			report_mismatch("outputs not idle after reset");

		for (k = 0; k < 4; k++) begin
			r = lcg_byte();
			d = lcg_byte();
			run_txn(1'b0, TB_DEV_ADDR, r, d, 1'b0, ok);
			assert (ok && !nack) else report_mismatch($sformatf("write to %h got nack", r));
			assert (slave_i.regs[r] == d) else
				report_mismatch($sformatf("reg %h = %h, expected %h", r, slave_i.regs[r], d));
			exp_regs[r] = d;
			written[r] = 1'b1;
			check_framing(1, 0, 1);
			run_txn(1'b1, TB_DEV_ADDR, r, 8'h00, 1'b0, ok);
			assert (ok && !nack && rd_data == d) else
				report_mismatch($sformatf("read %h gave %h nack %b, expected %h",
					r, rd_data, nack, d));
			check_framing(1, 1, 1);
		end

		for (k = 0; k < 4; k++) begin
			r = lcg_byte();
			while (written[r])
				r++;
			run_txn(1'b1, TB_DEV_ADDR, r, 8'h00, 1'b0, ok);
			assert (ok && !nack && rd_data == exp_regs[r]) else
				report_mismatch($sformatf("preload %h read %h, expected %h",
					r, rd_data, exp_regs[r]));
			check_framing(1, 1, 1);
		end

		// no slave at these addresses
		r = lcg_byte();
		d = lcg_byte();
		run_txn(1'b0, TB_DEV_ADDR ^ 7'h01, r, d, 1'b0, ok);
		assert (ok && nack) else report_mismatch("write to wrong address without nack");
		check_framing(1, 0, 1);
		run_txn(1'b1, TB_DEV_ADDR ^ 7'h10, r, 8'h00, 1'b0, ok);
		assert (ok && nack) else report_mismatch("read from wrong address without nack");
		check_framing(1, 0, 1);
		for (k = 0; k < 256; k++) begin
			assert (slave_i.regs[k] == exp_regs[k]) else
				report_mismatch($sformatf("reg %h changed to %h", k, slave_i.regs[k]));
		end

		r = lcg_byte();
		d = lcg_byte();
		run_txn(1'b0, TB_DEV_ADDR, r, d, 1'b1, ok);
		assert (ok && !nack && slave_i.regs[r] == d) else
			report_mismatch($sformatf("write %h to %h with extra start failed", d, r));
		check_framing(1, 0, 1);
		@(negedge clk_in);
		assert (!busy) else report_mismatch("busy rose again after the ignored start");

		errors = errors + slave_i.proto_errs;
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: sim.f
src/i2c_pkg.sv
src/i2c_byte_if.sv
src/i2c_bit_if.sv
src/i2c_txn_sequencer.sv
src/i2c_byte_shifter.sv
src/i2c_bit_engine.sv
src/i2c_master_top.sv
sim/i2c_slave_model.sv
sim/tb_i2c_master.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_i2c_master -f sim.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
	echo "result: PASS"
else
	echo "result: FAIL"
	exit 1
fi
